// File: dv/rename_checker.sv
`timescale 1ns/10ps
`include "rename_defines.svh"

module rename_checker (
	input  logic                   clock,
	input  logic                   reset,
	input  logic [31:0]            insn,
	input  logic                   dispatch_valid,
	input  logic                   dispatch_ready,
	input  rename_pkg::phys_tag_t  t_new,
	input  rename_pkg::phys_tag_t  t_old,
	input  rename_pkg::phys_tag_t  src1_tag,
	input  rename_pkg::phys_tag_t  src2_tag,
	input  logic [`PHYS_TAG_W:0]   num_free,
	input  logic                   retire,
	input  logic                   retire_pending,
	input  rename_pkg::arch_reg_t  retire_rd,
	input  rename_pkg::phys_tag_t  retire_t_new,
	input  logic [2:0]             phase,
	output int                     error_count
);

	import rename_pkg::*;

	// model of the free list with the oldest free tag first
	phys_tag_t free_model [$];
	phys_tag_t map_model [`NUM_ARCH_REG];

	// in-flight instructions in program order
	arch_reg_t rq_rd [$];
	phys_tag_t rq_t_new [$];
	phys_tag_t rq_t_old [$];

	// last edge had a dispatch and a retire together
	logic both_prev;
	// model free count before the last edge's update
	int   num_free_prev;

	// phase codes come from the testbench top
	function automatic string phase_name(input logic [2:0] code);
		case (code)
			3'd1:    return "reset_state";
			3'd2:    return "rename_lookup";
			3'd3:    return "exhaust_stall";
			3'd4:    return "in_order_retire";
			3'd5:    return "simultaneous";
			3'd6:    return "random_mix";
			default: return "reset";
		endcase
	endfunction

	// expected {t_new, t_old, src1, src2} from the map before the update
	function automatic logic [4*`PHYS_TAG_W-1:0] expected_tags(input arch_reg_t rd,
			input arch_reg_t rs1, input arch_reg_t rs2);
		return {free_model[0], map_model[rd], map_model[rs1], map_model[rs2]};
	endfunction

	task automatic compare_value(input string what, input int expected, input int actual);
		if (expected != actual) begin
			error_count = error_count + 1;
			$display("[FAIL] %s %s: expected %0d, actual %0d",
				phase_name(phase), what, expected, actual);
		end
	endtask

	task automatic reset_model();
		free_model.delete();
		rq_rd.delete();
		rq_t_new.delete();
		rq_t_old.delete();
		// tags below NUM_ARCH_REG are held by the identity map
		for (int i = `NUM_ARCH_REG; i < `NUM_PHYS_REG; i++) begin
			free_model.push_back(phys_tag_t'(i));
		end
		for (int i = 0; i < `NUM_ARCH_REG; i++) begin
			map_model[i] = phys_tag_t'(i);
		end
		both_prev = 1'b0;
	endtask

	always @(posedge clock) begin
		logic                     is_imm;
		arch_reg_t                rd;
		arch_reg_t                rs1;
		arch_reg_t                rs2;
		logic                     fire;
		logic                     ret;
		logic [4*`PHYS_TAG_W-1:0] exp_tags;
		arch_reg_t                head_rd;
		phys_tag_t                head_t_new;
		phys_tag_t                freed;
		if (reset) begin
			reset_model();
		end else begin
			// bit 31 is opcode bit 7 and is set for immediate format
			is_imm = insn[31];
			rd     = insn[23:20];
			rs1    = insn[19:16];
			rs2    = is_imm ? arch_reg_t'(0) : insn[15:12];
			fire   = dispatch_valid && (free_model.size() != 0);
			ret    = retire && (rq_rd.size() != 0);

			compare_value("dispatch_ready", int'(free_model.size() != 0), int'(dispatch_ready));
			compare_value("num_free", free_model.size(), int'(num_free));
			compare_value("retire_pending", int'(rq_rd.size() != 0), int'(retire_pending));
			if (both_prev)
				compare_value("num_free across fire and retire", num_free_prev, int'(num_free));
			num_free_prev = free_model.size();

			// oldest entry leaves first and is never this cycle's push
			if (ret) begin
				head_rd    = rq_rd.pop_front();
				head_t_new = rq_t_new.pop_front();
				freed      = rq_t_old.pop_front();
				compare_value("retire_rd", int'(head_rd), int'(retire_rd));
				compare_value("retire_t_new", int'(head_t_new), int'(retire_t_new));
			end

			if (fire) begin
				exp_tags = expected_tags(rd, rs1, rs2);
				compare_value("t_new", int'(exp_tags[3*`PHYS_TAG_W +: `PHYS_TAG_W]), int'(t_new));
				compare_value("t_old", int'(exp_tags[2*`PHYS_TAG_W +: `PHYS_TAG_W]), int'(t_old));
				compare_value("src1_tag", int'(exp_tags[`PHYS_TAG_W +: `PHYS_TAG_W]), int'(src1_tag));
				// src2 is meaningless for immediate format
				if (!is_imm)
					compare_value("src2_tag", int'(exp_tags[0 +: `PHYS_TAG_W]), int'(src2_tag));
				void'(free_model.pop_front());
				map_model[rd] = exp_tags[3*`PHYS_TAG_W +: `PHYS_TAG_W];
				rq_rd.push_back(rd);
				rq_t_new.push_back(exp_tags[3*`PHYS_TAG_W +: `PHYS_TAG_W]);
				rq_t_old.push_back(exp_tags[2*`PHYS_TAG_W +: `PHYS_TAG_W]);
			end

			// freed tag goes behind every tag already free
			if (ret)
				free_model.push_back(freed);

			if (rq_rd.size() > `RQ_DEPTH) begin
				error_count = error_count + 1;
				$display("more instructions in flight than the retire queue can hold");
			end

			both_prev = fire && ret;
		end
	end

endmodule

// File: dv/rename_properties.sv
`timescale 1ns/10ps
`include "rename_defines.svh"

module rename_properties (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   dispatch_valid,
	input  logic                   dispatch_ready,
	input  rename_pkg::phys_tag_t  t_new,
	input  rename_pkg::phys_tag_t  t_old,
	input  rename_pkg::phys_tag_t  src1_tag,
	input  rename_pkg::phys_tag_t  src2_tag,
	input  logic [`PHYS_TAG_W:0]   num_free
);

	// ready drops only right after the last free tag was handed out
	ready_falls_on_last_tag: assert property (
		@(posedge clock) disable iff (reset)
		$fell(dispatch_ready) |-> $past(dispatch_valid && (num_free == 1))
	) else $error("dispatch_ready fell without the last free tag being taken");

	// the map always holds NUM_ARCH_REG tags that the free list never sees
	count_within_capacity: assert property (
		@(posedge clock) disable iff (reset)
		num_free <= (`FL_SIZE - `NUM_ARCH_REG)
	) else $error("num_free above the number of tags the map does not hold");

	// a newly allocated tag is not mapped anywhere yet
	new_tag_is_fresh: assert property (
		@(posedge clock) disable iff (reset)
		(dispatch_valid && dispatch_ready) |->
			((src1_tag != t_new) && (src2_tag != t_new) && (t_old != t_new))
	) else $error("t_new collides with a source or old tag");

endmodule

// File: dv/rename_unit_tb.sv
`timescale 1ns/10ps
`include "rename_defines.svh"

module rename_unit_tb;

	import rename_pkg::*;

	localparam int CLOCK_PERIOD   = 100;
	localparam int RESET_CYCLES   = 2;
	localparam int STATE_CYCLES   = 4;
	localparam int LOOKUP_CYCLES  = 6;
	localparam int HOLD_CYCLES    = 4;
	localparam int IDLE_RETIRES   = 3;
	localparam int REFILL_CYCLES  = 8;
	localparam int PRELOAD_CYCLES = 4;
	localparam int BOTH_CYCLES    = 20;
	localparam int RANDOM_CYCLES  = 2000;
	// exhaust and retire loops each run about RQ_DEPTH cycles
	localparam int TOTAL_CYCLES = RESET_CYCLES + STATE_CYCLES + LOOKUP_CYCLES
		+ 2 * `RQ_DEPTH + HOLD_CYCLES + IDLE_RETIRES + REFILL_CYCLES
		+ PRELOAD_CYCLES + BOTH_CYCLES + RANDOM_CYCLES + 4;

	localparam logic [31:0] LCG_MUL  = 32'd1103515245;
	localparam logic [31:0] LCG_INC  = 32'd12345;
	localparam logic [31:0] LCG_SEED = 32'd84;

	// phase codes as the checker names them
	localparam logic [2:0] PH_RESET   = 3'd0;
	localparam logic [2:0] PH_STATE   = 3'd1;
	localparam logic [2:0] PH_LOOKUP  = 3'd2;
	localparam logic [2:0] PH_EXHAUST = 3'd3;
	localparam logic [2:0] PH_RETIRE  = 3'd4;
	localparam logic [2:0] PH_SIM     = 3'd5;
	localparam logic [2:0] PH_RANDOM  = 3'd6;

	logic                  clock = 1'b0;
	logic                  reset;
	insn_word_t            insn;
	logic                  dispatch_valid;
	logic                  dispatch_ready;
	phys_tag_t             t_new;
	phys_tag_t             t_old;
	phys_tag_t             src1_tag;
	phys_tag_t             src2_tag;
	logic [`PHYS_TAG_W:0]  num_free;
	logic                  retire;
	logic                  retire_pending;
	arch_reg_t             retire_rd;
	phys_tag_t             retire_t_new;
	logic [2:0]            phase;
	int                    error_count;
	logic [31:0]           lcg_state;

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	rename_unit u_rename_unit (.*);

	rename_checker u_rename_checker (.*);

	bind rename_unit rename_properties u_rename_properties (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * LCG_MUL + LCG_INC;
	endfunction

	// built from upper LCG bits since the low ones cycle quickly
	function automatic logic [31:0] random_word();
		logic [31:0] hi;
		lcg_state = lcg_next(lcg_state);
		hi = lcg_state;
		lcg_state = lcg_next(lcg_state);
		return {hi[31:16], lcg_state[31:16]};
	endfunction

	function automatic int random_pct();
		lcg_state = lcg_next(lcg_state);
		return int'(lcg_state[31:16]) % 100;
	endfunction

	function automatic insn_word_t make_insn(input logic imm, input arch_reg_t rd,
			input arch_reg_t rs1, input arch_reg_t rs2);
		insn_word_t w;
		if (imm) begin
			w.i.opcode = 8'h81;
			w.i.rd     = rd;
			w.i.rs1    = rs1;
			w.i.imm    = 16'h00a5;
		end else begin
			w.r.opcode = 8'h01;
			w.r.rd     = rd;
			w.r.rs1    = rs1;
			w.r.rs2    = rs2;
			w.r.func   = 12'h000;
		end
		return w;
	endfunction

	// keeps valid up until count instructions were accepted
	task automatic dispatch_some(input int count);
		int fired;
		fired = 0;
		dispatch_valid = 1'b1;
		while (fired < count) begin
			insn = random_word();
			if (dispatch_ready)
				fired++;
			@(negedge clock);
		end
		dispatch_valid = 1'b0;
	endtask

	initial begin
		reset          = 1'b1;
		insn           = '0;
		dispatch_valid = 1'b0;
		retire         = 1'b0;
		phase          = PH_RESET;
		lcg_state      = LCG_SEED;
		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;

		// first tag out is 16 and a source equal to rd still reads the old map
		phase = PH_STATE;
		dispatch_valid = 1'b1;
		insn = make_insn(1'b0, 4'd5, 4'd5, 4'd3);
		@(negedge clock);
		insn = make_insn(1'b1, 4'd2, 4'd5, 4'd0);
		@(negedge clock);
		dispatch_valid = 1'b0;
		repeat (STATE_CYCLES - 2) @(negedge clock);

		phase = PH_LOOKUP;
		dispatch_some(LOOKUP_CYCLES);

		// run the free list dry, then hold the stalled insn
		phase = PH_EXHAUST;
		dispatch_valid = 1'b1;
		while (dispatch_ready) begin
			insn = random_word();
			@(negedge clock);
		end
		repeat (HOLD_CYCLES) @(negedge clock);
		dispatch_valid = 1'b0;

		// drain in order while extra strobes on an empty queue are ignored
		phase = PH_RETIRE;
		retire = 1'b1;
		while (retire_pending) @(negedge clock);
		repeat (IDLE_RETIRES) @(negedge clock);
		retire = 1'b0;
		dispatch_some(REFILL_CYCLES);

		phase = PH_SIM;
		dispatch_some(PRELOAD_CYCLES);
		dispatch_valid = 1'b1;
		retire = 1'b1;
		repeat (BOTH_CYCLES) begin
			insn = random_word();
			@(negedge clock);
		end
		dispatch_valid = 1'b0;
		retire = 1'b0;

		phase = PH_RANDOM;
		repeat (RANDOM_CYCLES) begin
			// a stalled request keeps its valid and its word
			if (!(dispatch_valid && !dispatch_ready)) begin
				dispatch_valid = (random_pct() < 70);
				insn = random_word();
			end
			retire = (random_pct() < 50);
			@(negedge clock);
		end
		dispatch_valid = 1'b0;
		retire = 1'b0;
		repeat (2) @(negedge clock);

		$display("run complete, %0d errors", error_count);
		if (error_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// bound from the phase lengths plus margin
	initial begin
		#((TOTAL_CYCLES + 100) * CLOCK_PERIOD);
		$display("timeout, run still busy after %0d cycles", TOTAL_CYCLES + 100);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: rename_unit.f
+incdir+rtl
rtl/rename_pkg.sv
rtl/free_list.sv
rtl/map_table.sv
rtl/retire_queue.sv
rtl/rename_unit.sv
dv/rename_properties.sv
dv/rename_checker.sv
dv/rename_unit_tb.sv

// File: rtl/free_list.sv
`timescale 1ns/10ps
`include "rename_defines.svh"

module free_list (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   pop,
	input  logic                   push,
	input  rename_pkg::phys_tag_t  push_tag,
	output rename_pkg::phys_tag_t  free_reg,
	output logic [`PHYS_TAG_W:0]   num_free,
	output logic                   empty
);

	import rename_pkg::*;

	// queue storage, entry 0 is the oldest free tag
	phys_tag_t free_q [`FL_SIZE];
	phys_tag_t next_free_q [`FL_SIZE];

	// tail is the first empty slot and doubles as the count
	logic [`PHYS_TAG_W:0] tail;
	logic [`PHYS_TAG_W:0] next_tail;
	logic [`PHYS_TAG_W:0] tail_m1;

	// a pop on an empty queue is ignored
	logic do_pop;

	assign empty    = (tail == '0);
	assign free_reg = free_q[0];
	assign num_free = tail;
	assign do_pop   = pop && !empty;
	assign tail_m1  = tail - 1'b1;

	always_comb begin
		next_free_q = free_q;
		next_tail   = tail;
		if (do_pop) begin
			// shift everything one slot toward the head
			for (int i = 0; i < `FL_SIZE - 1; i++) begin
				next_free_q[i] = free_q[i+1];
			end
			if (push) begin
				// head leaves, freed tag lands in the slot the shift opened
				next_free_q[tail_m1[`PHYS_TAG_W-1:0]] = push_tag;
			end else begin
				next_tail = tail_m1;
			end
		end else if (push) begin
			// full queue drops the push, cannot happen with the depth rule
			if (tail != `FL_SIZE) begin
				next_free_q[tail[`PHYS_TAG_W-1:0]] = push_tag;
				next_tail = tail + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			// map table owns tags 0..NUM_ARCH_REG-1 after reset
			// the rest start out free, lowest first
			for (int i = 0; i < `FL_SIZE - `NUM_ARCH_REG; i++) begin
				free_q[i] <= phys_tag_t'(`NUM_ARCH_REG + i);
			end
			tail <= (`PHYS_TAG_W+1)'(`FL_SIZE - `NUM_ARCH_REG);
		end else begin
			free_q <= next_free_q;
			tail   <= next_tail;
		end
	end

endmodule

// File: rtl/map_table.sv
`timescale 1ns/10ps
`include "rename_defines.svh"

module map_table (
	input  logic                   clock,
	input  logic                   reset,
	input  rename_pkg::arch_reg_t  rs1,
	input  rename_pkg::arch_reg_t  rs2,
	input  rename_pkg::arch_reg_t  rd,
	input  logic                   write,
	input  rename_pkg::phys_tag_t  new_tag,
	output rename_pkg::phys_tag_t  src1_tag,
	output rename_pkg::phys_tag_t  src2_tag,
	output rename_pkg::phys_tag_t  old_tag
);

	import rename_pkg::*;

	// speculative mapping, one tag per architectural register
	phys_tag_t map_q [`NUM_ARCH_REG];

	// read ports are combinational and see the mapping before
	// this cycle's write, so a source equal to rd gets the old tag
	assign src1_tag = map_q[rs1];
	assign src2_tag = map_q[rs2];

	// the tag being replaced, freed when this instruction retires
	assign old_tag = map_q[rd];

	always_ff @(posedge clock) begin
		if (reset) begin
			// identity mapping, register i lives in tag i
			for (int i = 0; i < `NUM_ARCH_REG; i++) begin
				map_q[i] <= phys_tag_t'(i);
			end
		end else if (write) begin
			// rd now points at the freshly allocated tag
			map_q[rd] <= new_tag;
		end
	end

endmodule

// File: rtl/rename_defines.svh
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// architectural register file size seen by software
`define NUM_ARCH_REG 16

// physical register file size behind the rename stage
`define NUM_PHYS_REG 32

// free list can hold every physical tag
`define FL_SIZE `NUM_PHYS_REG

// at most this many tags are in flight between rename and retire
`define RQ_DEPTH (`NUM_PHYS_REG - `NUM_ARCH_REG)

// tag and register number widths
`define PHYS_TAG_W 5
`define ARCH_REG_W 4

`endif

// File: rtl/rename_pkg.sv
`include "rename_defines.svh"

package rename_pkg;

	// physical register tag
	typedef logic [`PHYS_TAG_W-1:0] phys_tag_t;

	// architectural register number
	typedef logic [`ARCH_REG_W-1:0] arch_reg_t;

	// register format, two sources and a function field
	typedef struct packed {
		logic [7:0]  opcode;
		arch_reg_t   rd;
		arch_reg_t   rs1;
		arch_reg_t   rs2;
		logic [11:0] func;
	} r_fmt_t;

	// immediate format, one source and a 16-bit immediate
	typedef struct packed {
		logic [7:0]  opcode;
		arch_reg_t   rd;
		arch_reg_t   rs1;
		logic [15:0] imm;
	} i_fmt_t;

	// one 32-bit word, decoded by opcode bit 7
	// bit 7 set selects the immediate view
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} insn_word_t;

endpackage

// File: rtl/rename_unit.sv
`timescale 1ns/10ps
`include "rename_defines.svh"

module rename_unit (
	input  logic                   clock,
	input  logic                   reset,
	input  rename_pkg::insn_word_t insn,
	input  logic                   dispatch_valid,
	output logic                   dispatch_ready,
	output rename_pkg::phys_tag_t  t_new,
	output rename_pkg::phys_tag_t  t_old,
	output rename_pkg::phys_tag_t  src1_tag,
	output rename_pkg::phys_tag_t  src2_tag,
	output logic [`PHYS_TAG_W:0]   num_free,
	input  logic                   retire,
	output logic                   retire_pending,
	output rename_pkg::arch_reg_t  retire_rd,
	output rename_pkg::phys_tag_t  retire_t_new
);

	import rename_pkg::*;

	// decoded register fields
	logic      is_imm;
	arch_reg_t dec_rd;
	arch_reg_t dec_rs1;
	arch_reg_t dec_rs2;

	// handshake
	logic dispatch_fire;
	logic fl_empty;

	// free list head handed to this instruction
	phys_tag_t free_reg;

	// map lookup of the destination's current tag
	phys_tag_t old_tag;

	// retire side back to the free list
	logic      freed_valid;
	phys_tag_t freed_tag;

	// opcode sits in the same bits in both views
	assign is_imm = insn.i.opcode[7];

	// rd and rs1 also sit in the same bits in both views
	assign dec_rd  = insn.i.rd;
	assign dec_rs1 = insn.i.rs1;

	// immediate format has no second source so rs2 looks up register 0
	assign dec_rs2 = is_imm ? '0 : insn.r.rs2;

	// stall whenever no physical register is left
	assign dispatch_ready = !fl_empty;
	assign dispatch_fire  = dispatch_valid && dispatch_ready;

	assign t_new = free_reg;
	assign t_old = old_tag;

	// freed tags come back in at the tail
	free_list u_free_list (
		.clock    (clock),
		.reset    (reset),
		.pop      (dispatch_fire),
		.push     (freed_valid),
		.push_tag (freed_tag),
		.free_reg (free_reg),
		.num_free (num_free),
		.empty    (fl_empty)
	);

	// lookups are combinational and the write lands at the next edge
	map_table u_map_table (
		.clock    (clock),
		.reset    (reset),
		.rs1      (dec_rs1),
		.rs2      (dec_rs2),
		.rd       (dec_rd),
		.write    (dispatch_fire),
		.new_tag  (free_reg),
		.src1_tag (src1_tag),
		.src2_tag (src2_tag),
		.old_tag  (old_tag)
	);

	// keeps the old tag until the instruction retires in order
	retire_queue u_retire_queue (
		.clock          (clock),
		.reset          (reset),
		.push           (dispatch_fire),
		.push_rd        (dec_rd),
		.push_t_new     (free_reg),
		.push_t_old     (old_tag),
		.retire         (retire),
		.retire_pending (retire_pending),
		.freed_valid    (freed_valid),
		.freed_tag      (freed_tag),
		.retire_t_new   (retire_t_new),
		.retire_rd      (retire_rd)
	);

endmodule

// File: rtl/retire_queue.sv
`timescale 1ns/10ps
`include "rename_defines.svh"

module retire_queue (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   push,
	input  rename_pkg::arch_reg_t  push_rd,
	input  rename_pkg::phys_tag_t  push_t_new,
	input  rename_pkg::phys_tag_t  push_t_old,
	input  logic                   retire,
	output logic                   retire_pending,
	output logic                   freed_valid,
	output rename_pkg::phys_tag_t  freed_tag,
	output rename_pkg::phys_tag_t  retire_t_new,
	output rename_pkg::arch_reg_t  retire_rd
);

	import rename_pkg::*;

	// per-entry payload
	arch_reg_t rd_q    [`RQ_DEPTH];
	phys_tag_t t_new_q [`RQ_DEPTH];
	phys_tag_t t_old_q [`RQ_DEPTH];

	// head is the oldest entry and tail the next free slot
	logic [$clog2(`RQ_DEPTH)-1:0] head;
	logic [$clog2(`RQ_DEPTH)-1:0] tail;
	logic [$clog2(`RQ_DEPTH):0]   count;

	logic full;
	logic do_push;

	assign retire_pending = (count != '0);
	assign full           = (count == `RQ_DEPTH);

	// the only place a retire strobe is checked against occupancy
	assign freed_valid = retire && retire_pending;

	// a push into a full queue is only taken when the head leaves too
	assign do_push = push && (!full || freed_valid);

	// oldest entry is always visible
	assign freed_tag    = t_old_q[head];
	assign retire_t_new = t_new_q[head];
	assign retire_rd    = rd_q[head];

	// payload write at the tail
	always_ff @(posedge clock) begin
		if (do_push) begin
			rd_q[tail]    <= push_rd;
			t_new_q[tail] <= push_t_new;
			t_old_q[tail] <= push_t_old;
		end
	end

	// pointers and occupancy
	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				if (tail == $clog2(`RQ_DEPTH)'(`RQ_DEPTH - 1))
					tail <= '0;
				else
					tail <= tail + 1'b1;
			end
			if (freed_valid) begin
				if (head == $clog2(`RQ_DEPTH)'(`RQ_DEPTH - 1))
					head <= '0;
				else
					head <= head + 1'b1;
			end
			// push and pop together leave the count alone
			if (do_push && !freed_valid)
				count <= count + 1'b1;
			else if (!do_push && freed_valid)
				count <= count - 1'b1;
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# build and run the rename unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
	-f rename_unit.f \
	--top-module rename_unit_tb \
	-o rename_unit_sim

# the simulator status is not trusted, the log decides
./obj_dir/rename_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation PASSED$" sim.log; then
	exit 0
fi
exit 1
